// ==== lane_data_pkg.sv ====
/* Datapath types: data word, register and bank indices,
   status flags and the write-back bus */

`default_nettype none

package lane_data_pkg;

	localparam int word_width	= 32;
	localparam int num_regs		= 32;
	localparam int idx_width	= $clog2(num_regs);
	localparam int bank_depth	= num_regs / 2;		// Odd and even halves

	typedef logic [word_width-1:0]	data_t;

	// Top bit picks the bank, 1 is odd
	typedef logic [idx_width-1:0]	reg_idx_t;
	typedef logic [idx_width-2:0]	bank_idx_t;

	typedef struct packed {
		logic	zero;
		logic	negative;
		logic	carry;
	} status_t;

	typedef struct packed {
		logic		valid;
		reg_idx_t	dst;
		data_t		data;
	} wb_t;

endpackage

`default_nettype wire

// ==== lane_isa_pkg.sv ====
/* Command set: opcodes, operand field union, command and
   read-stage structs, decode helpers */

`default_nettype none

package lane_isa_pkg;

	localparam int imm_width	= 16;
	localparam int pad_width	= imm_width - 2 * lane_data_pkg::idx_width;

	typedef enum logic [3:0] {
		op_add	= 4'h0,
		op_sub	= 4'h1,
		op_and	= 4'h2,
		op_or	= 4'h3,
		op_xor	= 4'h4,
		op_shl	= 4'h5,
		op_shr	= 4'h6,
		op_li	= 4'h7,		// Zero-extended
		op_addi	= 4'h8,		// Sign-extended, adds to dst
		op_cmp	= 4'h9		// Flags only
	} opcode_t;

	// Same 16 bits, two sources or one immediate
	typedef union packed {
		struct packed {
			logic [pad_width-1:0]		pad;
			lane_data_pkg::reg_idx_t	src_a;
			lane_data_pkg::reg_idx_t	src_b;
		} regs;
		logic [imm_width-1:0]	imm;
	} operand_t;

	typedef struct packed {
		logic						valid;
		opcode_t					opcode;
		lane_data_pkg::reg_idx_t	dst;
		operand_t					operand;
	} lane_cmd_t;

	typedef struct packed {
		logic						valid;
		opcode_t					opcode;
		lane_data_pkg::reg_idx_t	dst;
		lane_data_pkg::data_t		a_data;
		lane_data_pkg::data_t		b_data;
	} read_stage_t;

	function automatic logic uses_imm(input opcode_t op);
		return (op == op_li) || (op == op_addi);
	endfunction

	function automatic logic writes_dst(input opcode_t op);
		return op != op_cmp;
	endfunction

endpackage

`default_nettype wire

// ==== reg_bank.sv ====
/* One half of the lane register file, two async read ports
   and one write port */

`timescale 1ns/10ps
`default_nettype none

module reg_bank (
	input	wire logic						clock,
	input	wire logic						reset,
	input	wire logic						we,
	input	wire lane_data_pkg::bank_idx_t	wr_idx,
	input	wire lane_data_pkg::data_t		wr_data,
	input	wire lane_data_pkg::bank_idx_t	rd_idx_a,
	input	wire lane_data_pkg::bank_idx_t	rd_idx_b,
	output	lane_data_pkg::data_t			rd_data_a,
	output	lane_data_pkg::data_t			rd_data_b
);
	import lane_data_pkg::*;

	data_t	mem [bank_depth];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < bank_depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_idx] <= wr_data;
		end
	end

	// No bypass here, forwarding lives in the read stage
	assign rd_data_a = mem[rd_idx_a];
	assign rd_data_b = mem[rd_idx_b];

endmodule

`default_nettype wire

// ==== status_reg.sv ====
/* Lane status flags, kept across commands that do not set them */

`timescale 1ns/10ps
`default_nettype none

module status_reg (
	input	wire logic						clock,
	input	wire logic						reset,
	input	wire logic						flags_valid,
	input	wire lane_data_pkg::status_t	flags,
	output	lane_data_pkg::status_t			status
);
	import lane_data_pkg::*;

	always_ff @(posedge clock) begin
		if (reset)
			status <= '0;
		else if (flags_valid)
			status <= flags;
	end

	// An update never loads unknown flags
	a_status_hold: assert property (@(posedge clock) disable iff (reset)
		flags_valid |-> !$isunknown(flags));

endmodule

`default_nettype wire

// ==== lane_alu.sv ====
/* Execute stage: opcode datapath, flag generation and the
   write-back register */

`timescale 1ns/10ps
`default_nettype none

module lane_alu (
	input	wire logic						clock,
	input	wire logic						reset,
	input	wire lane_isa_pkg::read_stage_t	rd,
	output	lane_data_pkg::wb_t				alu_fwd,
	output	lane_data_pkg::wb_t				wb,
	output	logic							flags_valid,
	output	lane_data_pkg::status_t			flags
);
	import lane_data_pkg::*;
	import lane_isa_pkg::*;

	logic [word_width:0]	sum;		// Extra bit for carry
	data_t					imm_sext;
	data_t					result;
	status_t				flags_next;

	assign imm_sext = {{(word_width-imm_width){rd.b_data[imm_width-1]}},
		rd.b_data[imm_width-1:0]};

	always_comb begin
		sum		= '0;
		result	= '0;
		case (rd.opcode)
			op_add:			sum = {1'b0, rd.a_data} + {1'b0, rd.b_data};
			op_sub, op_cmp:	sum = {1'b0, rd.a_data} - {1'b0, rd.b_data};	// Borrow in top bit
			op_addi:		sum = {1'b0, rd.a_data} + {1'b0, imm_sext};
			op_and:			result = rd.a_data & rd.b_data;
			op_or:			result = rd.a_data | rd.b_data;
			op_xor:			result = rd.a_data ^ rd.b_data;
			op_shl:			result = rd.a_data << rd.b_data[4:0];
			op_shr:			result = rd.a_data >> rd.b_data[4:0];
			op_li:			result = rd.b_data;
			default:		result = '0;
		endcase
		if (rd.opcode inside {op_add, op_sub, op_cmp, op_addi})
			result = sum[word_width-1:0];
	end

	assign flags_next.zero		= (result == '0);
	assign flags_next.negative	= result[word_width-1];
	assign flags_next.carry		= sum[word_width];

	// Forward path, unregistered
	assign alu_fwd.valid	= rd.valid && writes_dst(rd.opcode);
	assign alu_fwd.dst		= rd.dst;
	assign alu_fwd.data		= result;

	// Status register latches these at the wb edge
	assign flags_valid	= rd.valid && (rd.opcode != op_li);
	assign flags		= flags_next;

	always_ff @(posedge clock) begin
		wb <= alu_fwd;
		if (reset) begin
			wb.valid <= 1'b0;
		end
	end

	// Committed data never carries unknown bits
	a_wb_writes: assert property (@(posedge clock) disable iff (reset)
		wb.valid |-> !$isunknown(wb.data));

endmodule

`default_nettype wire

// ==== operand_read.sv ====
/* Read stage: odd/even banks, write-back steering, operand
   forwarding and the read-stage pipeline register */

`timescale 1ns/10ps
`default_nettype none

module operand_read (
	input	wire logic						clock,
	input	wire logic						reset,
	input	wire lane_isa_pkg::lane_cmd_t	cmd,
	input	wire lane_data_pkg::wb_t		wb,
	input	wire lane_data_pkg::wb_t		alu_fwd,
	output	lane_isa_pkg::read_stage_t		rd
);
	import lane_data_pkg::*;
	import lane_isa_pkg::*;

	reg_idx_t		src_a;
	reg_idx_t		src_b;
	logic			we_odd;
	logic			we_even;
	data_t			odd_a;
	data_t			odd_b;
	data_t			even_a;
	data_t			even_b;
	data_t			bank_a;
	data_t			bank_b;
	read_stage_t	rd_next;

	// Newest value wins: ALU result, then wb register, then bank
	function automatic data_t forward(
		input reg_idx_t	idx,
		input data_t	bank_val,
		input wb_t		near,
		input wb_t		far
	);
		if (near.valid && near.dst == idx)
			return near.data;
		if (far.valid && far.dst == idx)
			return far.data;
		return bank_val;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bank access

	// Immediate forms take operand A from dst
	assign src_a	= uses_imm(cmd.opcode) ? cmd.dst : cmd.operand.regs.src_a;
	assign src_b	= cmd.operand.regs.src_b;

	assign we_odd	= wb.valid &  wb.dst[idx_width-1];
	assign we_even	= wb.valid & ~wb.dst[idx_width-1];

	reg_bank bank_odd (
		.clock		(clock),
		.reset		(reset),
		.we			(we_odd),
		.wr_idx		(wb.dst[idx_width-2:0]),
		.wr_data	(wb.data),
		.rd_idx_a	(src_a[idx_width-2:0]),
		.rd_idx_b	(src_b[idx_width-2:0]),
		.rd_data_a	(odd_a),
		.rd_data_b	(odd_b)
	);

	reg_bank bank_even (
		.clock		(clock),
		.reset		(reset),
		.we			(we_even),
		.wr_idx		(wb.dst[idx_width-2:0]),
		.wr_data	(wb.data),
		.rd_idx_a	(src_a[idx_width-2:0]),
		.rd_idx_b	(src_b[idx_width-2:0]),
		.rd_data_a	(even_a),
		.rd_data_b	(even_b)
	);

	assign bank_a = src_a[idx_width-1] ? odd_a : even_a;
	assign bank_b = src_b[idx_width-1] ? odd_b : even_b;

	////////////////////////////////////////////////////////////////////////////
	// Operand select and pipeline register

	always_comb begin
		rd_next.valid	= cmd.valid;
		rd_next.opcode	= cmd.opcode;
		rd_next.dst		= cmd.dst;
		rd_next.a_data	= forward(src_a, bank_a, alu_fwd, wb);
		if (uses_imm(cmd.opcode))
			rd_next.b_data = data_t'(cmd.operand.imm);	// Raw imm, ALU extends
		else
			rd_next.b_data = forward(src_b, bank_b, alu_fwd, wb);
	end

	always_ff @(posedge clock) begin
		rd <= rd_next;
		if (reset)
			rd.valid <= 1'b0;
	end

	// A committed result has a known destination
	a_wb_target: assert property (@(posedge clock) disable iff (reset)
		wb.valid |-> !$isunknown(wb.dst));

endmodule

`default_nettype wire

// ==== lane_unit.sv ====
/* Vector lane top: read stage, ALU and status register */

`timescale 1ns/10ps
`default_nettype none

module lane_unit (
	input	wire logic						clock,
	input	wire logic						reset,
	input	wire lane_isa_pkg::lane_cmd_t	cmd,
	output	lane_data_pkg::wb_t				wb,
	output	logic							commit,
	output	lane_data_pkg::status_t			status
);
	import lane_data_pkg::*;
	import lane_isa_pkg::*;

	read_stage_t	rd;
	wb_t			alu_fwd;
	logic			flags_valid;
	status_t		flags;

	////////////////////////////////////////////////////////////////////////////
	// Pipeline

	operand_read operand_read0 (
		.clock		(clock),
		.reset		(reset),
		.cmd		(cmd),
		.wb			(wb),
		.alu_fwd	(alu_fwd),
		.rd			(rd)
	);

	lane_alu lane_alu0 (
		.clock			(clock),
		.reset			(reset),
		.rd				(rd),
		.alu_fwd		(alu_fwd),
		.wb				(wb),
		.flags_valid	(flags_valid),
		.flags			(flags)
	);

	status_reg status_reg0 (
		.clock			(clock),
		.reset			(reset),
		.flags_valid	(flags_valid),
		.flags			(flags),
		.status			(status)
	);

	assign commit = wb.valid;		// Two cycles after issue

endmodule

`default_nettype wire

// ==== lane_unit_tb.sv ====
/* Lane unit testbench: clock and reset, directed and random
   command streams, register and flag model, checking assertions */

`timescale 1ns/10ps
`default_nettype none

module lane_unit_tb;
	import lane_data_pkg::*;
	import lane_isa_pkg::*;

	localparam int clk_period		= 4;
	localparam int reset_cycles		= 10;
	localparam int num_random		= 300;
	localparam int max_gap			= 3;
	localparam int directed_slots	= 80;
	localparam int timeout_ns		= (reset_cycles + directed_slots
		+ num_random * (max_gap + 1) + 100) * clk_period;

	logic		clock;
	logic		reset;
	lane_cmd_t	cmd;
	wb_t		wb;
	logic		commit;
	status_t	status;

	integer		seed = 32'hec14_3d60;
	data_t		model_regs [num_regs];
	status_t	model_status;
	wb_t		issue_exp;			// Write-back of the command driven this cycle
	wb_t		exp_wb [2];			// Read stage, execute stage
	status_t	exp_st [2];			// Same lag as write-back
	int			expected_commits = 0;
	int			commits = 0;

	lane_unit dut0 (
		.clock	(clock),
		.reset	(reset),
		.cmd	(cmd),
		.wb		(wb),
		.commit	(commit),
		.status	(status)
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	initial begin
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		$display("CHECKS FAILED");
		$fatal(1, "Watchdog expired");
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Fail %s expected %h actual %h", name, expected, actual);
		$display("CHECKS FAILED");
		$fatal(1, "Mismatch on %s", name);
	endtask

	function automatic operand_t two_src(input reg_idx_t a, input reg_idx_t b);
		operand_t opnd;
		opnd = '0;
		opnd.regs.src_a = a;
		opnd.regs.src_b = b;
		return opnd;
	endfunction

	function automatic operand_t immediate(input logic [15:0] value);
		operand_t opnd;
		opnd.imm = value;
		return opnd;
	endfunction

	// Drive one command and run it through the model in issue order
	task automatic issue(input opcode_t op, input reg_idx_t dst, input operand_t opnd);
		data_t			a;
		data_t			b;
		data_t			res;
		logic [32:0]	sum;
		logic			carry;
		@(posedge clock);
		#1;
		cmd.valid	= 1'b1;
		cmd.opcode	= op;
		cmd.dst		= dst;
		cmd.operand	= opnd;
		a = (op == op_li || op == op_addi) ? model_regs[dst] : model_regs[opnd.regs.src_a];
		b = model_regs[opnd.regs.src_b];
		res		= '0;
		carry	= 1'b0;
		case (op)
			op_add: begin
				sum		= {1'b0, a} + {1'b0, b};
				res		= sum[31:0];
				carry	= sum[32];
			end
			op_sub, op_cmp: begin
				res		= a - b;
				carry	= (a < b);		// Borrow
			end
			op_and:	res = a & b;
			op_or:	res = a | b;
			op_xor:	res = a ^ b;
			op_shl:	res = a << b[4:0];
			op_shr:	res = a >> b[4:0];
			op_li:	res = {16'h0000, opnd.imm};
			op_addi: begin
				sum		= {1'b0, a} + {1'b0, {{16{opnd.imm[15]}}, opnd.imm}};
				res		= sum[31:0];
				carry	= sum[32];
			end
			default: res = '0;
		endcase
		if (op != op_li) begin
			model_status.zero		= (res == 32'h0);
			model_status.negative	= res[31];
			model_status.carry		= carry;
		end
		if (op != op_cmp) begin
			model_regs[dst] = res;
			expected_commits++;
		end
		issue_exp.valid	= (op != op_cmp);
		issue_exp.dst	= dst;
		issue_exp.data	= res;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			#1;
			cmd.valid		= 1'b0;
			issue_exp.valid	= 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Expected pipeline and checks

	always @(posedge clock) begin
		if (reset) begin
			exp_wb[0]	<= '0;
			exp_wb[1]	<= '0;
			exp_st[0]	<= '0;
			exp_st[1]	<= '0;
		end else begin
			exp_wb[0]	<= issue_exp;
			exp_wb[1]	<= exp_wb[0];
			exp_st[0]	<= model_status;
			exp_st[1]	<= exp_st[0];
		end
	end

	always @(negedge clock) begin
		if (!reset && commit)
			commits <= commits + 1;
	end

	a_commit: assert property (@(posedge clock) disable iff (reset)
		commit == exp_wb[1].valid)
		else report_mismatch("commit", 32'($sampled(exp_wb[1].valid)), 32'($sampled(commit)));

	a_wb_valid: assert property (@(posedge clock) disable iff (reset)
		wb.valid == exp_wb[1].valid)
		else report_mismatch("wb.valid", 32'($sampled(exp_wb[1].valid)),
			32'($sampled(wb.valid)));

	a_wb_dst: assert property (@(posedge clock) disable iff (reset)
		exp_wb[1].valid |-> wb.dst == exp_wb[1].dst)
		else report_mismatch("wb.dst", 32'($sampled(exp_wb[1].dst)), 32'($sampled(wb.dst)));

	a_wb_data: assert property (@(posedge clock) disable iff (reset)
		exp_wb[1].valid |-> wb.data == exp_wb[1].data)
		else report_mismatch("wb.data", $sampled(exp_wb[1].data), $sampled(wb.data));

	a_status: assert property (@(posedge clock) disable iff (reset)
		status == exp_st[1])
		else report_mismatch("status", 32'($sampled(exp_st[1])), 32'($sampled(status)));

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [31:0]	rnd;
		logic [31:0]	rnd2;
		opcode_t		op;
		reset			= 1'b1;
		cmd				= '0;
		issue_exp		= '0;
		model_status	= '0;
		for (int i = 0; i < num_regs; i++)
			model_regs[i] = '0;
		repeat (reset_cycles) @(posedge clock);
		#1 reset = 1'b0;

		idle(3);
		issue(op_add, 5'd5, two_src(5'd1, 5'd2));		// Unwritten registers
		idle(3);
		issue(op_li, 5'd3, immediate(16'h1234));		// Even bank
		issue(op_li, 5'd20, immediate(16'h8001));		// Odd bank
		issue(op_li, 5'd7, immediate(16'hffff));
		issue(op_li, 5'd30, immediate(16'h00f0));
		idle(2);
		// Dependency chains, one and two commands apart
		issue(op_add, 5'd8, two_src(5'd3, 5'd20));
		issue(op_sub, 5'd9, two_src(5'd8, 5'd3));
		issue(op_xor, 5'd10, two_src(5'd9, 5'd8));
		issue(op_add, 5'd11, two_src(5'd3, 5'd3));
		issue(op_or, 5'd12, two_src(5'd7, 5'd30));
		issue(op_and, 5'd13, two_src(5'd11, 5'd12));
		issue(op_shl, 5'd14, two_src(5'd13, 5'd30));
		issue(op_shr, 5'd15, two_src(5'd14, 5'd3));
		idle(2);
		// Cross-bank operands, then immediate forms
		issue(op_add, 5'd21, two_src(5'd20, 5'd3));
		issue(op_addi, 5'd21, immediate(16'hfff0));
		issue(op_addi, 5'd3, immediate(16'h0010));
		issue(op_sub, 5'd31, two_src(5'd21, 5'd3));
		idle(3);
		// Flags only: equal, then a borrow; a load keeps them
		issue(op_cmp, 5'd0, two_src(5'd3, 5'd3));
		idle(4);
		issue(op_cmp, 5'd0, two_src(5'd3, 5'd20));
		issue(op_li, 5'd2, immediate(16'h0000));
		idle(4);

		for (int n = 0; n < num_random; n++) begin
			rnd		= $random(seed);
			rnd2	= $random(seed);
			op		= opcode_t'(rnd[3:0] % 4'd10);
			if (op == op_li || op == op_addi)
				issue(op, rnd2[4:0], immediate(rnd[31:16]));
			else
				issue(op, rnd2[4:0], two_src(rnd2[9:5], rnd2[14:10]));
			idle(int'(rnd2[17:16]));
		end
		idle(6);

		if (commits != expected_commits) begin
			$display("Commit count is wrong: %0d seen, %0d expected", commits,
				expected_commits);
			$display("CHECKS FAILED");
			$fatal(1, "Commit count");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
lane_data_pkg.sv
lane_isa_pkg.sv
reg_bank.sv
status_reg.sv
lane_alu.sv
operand_read.sv
lane_unit.sv
lane_unit_tb.sv

// ==== Makefile ====
TOP = lane_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@if grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "Simulation passed"; \
	else \
		cat sim.log; \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
